// ==== verilog/ckPkg.sv ====
package ckPkg;

  // Data word, adder operand or adder sum.
  typedef logic [15:0] wordT;

  // Running byte count.
  typedef logic [15:0] countT;

  // Clients of the shared adder.
  typedef enum logic {
    clientAcc,
    clientCnt
  } clientT;

  // Accumulator FSM.
  typedef enum logic [1:0] {
    accIdle,
    accAdd,
    accFold
  } accStateT;

  localparam int WordStride = 2;  // Bytes per word.

endpackage

// ==== verilog/claAdd15.sv ====
`timescale 1ns/1ps

module claAdd15 (
  input  logic [15:1] a,
  input  logic [15:1] b,
  input  logic        cin,
  output logic [15:1] sum
);

  logic [14:1] p;
  logic [14:1] g;
  logic [15:1] ps;
  logic        gs;
  logic [7:1]  g1;
  logic [7:2]  p1;
  logic [3:1]  g2;
  logic [3:2]  p2;
  logic        g3;
  logic [14:1] c;

  assign p  = a[14:1] | b[14:1];
  assign g  = a[14:1] & b[14:1];
  assign ps = a ^ b;

  assign gs = g[1] | (p[1] & cin);  // Carry into bit 1 joins the first group.

  // Pairs of bits.
  assign g1[1] = g[2]  | (p[2]  & gs);
  assign g1[2] = g[4]  | (p[4]  & g[3]);
  assign g1[3] = g[6]  | (p[6]  & g[5]);
  assign g1[4] = g[8]  | (p[8]  & g[7]);
  assign g1[5] = g[10] | (p[10] & g[9]);
  assign g1[6] = g[12] | (p[12] & g[11]);
  assign g1[7] = g[14] | (p[14] & g[13]);

  assign p1[2] = p[4]  & p[3];
  assign p1[3] = p[6]  & p[5];
  assign p1[4] = p[8]  & p[7];
  assign p1[5] = p[10] & p[9];
  assign p1[6] = p[12] & p[11];
  assign p1[7] = p[14] & p[13];

  // Groups of four.
  assign g2[1] = g1[2] | (p1[2] & g1[1]);
  assign g2[2] = g1[4] | (p1[4] & g1[3]);
  assign g2[3] = g1[6] | (p1[6] & g1[5]);

  assign p2[2] = p1[4] & p1[3];
  assign p2[3] = p1[6] & p1[5];

  // Group of eight, bits 8:1.
  assign g3 = g2[2] | (p2[2] & g2[1]);

  // c[i] is the carry out of bit i.
  assign c[1]  = gs;
  assign c[2]  = g1[1];
  assign c[3]  = g[3] | (g1[1] & p[3]);
  assign c[4]  = g2[1];
  assign c[5]  = g[5] | (g2[1] & p[5]);
  assign c[6]  = g1[3] | (g2[1] & p1[3]);
  assign c[7]  = g[7] | (c[6] & p[7]);
  assign c[8]  = g3;
  assign c[9]  = g[9] | (g3 & p[9]);
  assign c[10] = g1[5] | (g3 & p1[5]);
  assign c[11] = g[11] | (g1[5] & p[11]) |
                 (g3 & p1[5] & p[11]);
  assign c[12] = g2[3] | (g3 & p2[3]);
  assign c[13] = g[13] | (g2[3] & p[13]) |
                 (g3 & p2[3] & p[13]);
  assign c[14] = g1[7] | (g2[3] & p1[7]) |
                 (g3 & p2[3] & p1[7]);

  assign sum = ps ^ {c, cin};  // No carry out of bit 15 here.

endmodule

// ==== verilog/adderShare.sv ====
`timescale 1ns/1ps

module adderShare (
  input  logic         clk,
  input  logic         rstN,
  input  logic         reqAcc,
  input  logic         reqCnt,
  input  ckPkg::wordT  accA,
  input  ckPkg::wordT  accB,
  input  logic         accCin,
  input  ckPkg::countT cntA,
  input  ckPkg::countT cntB,
  output logic         grantAcc,
  output logic         grantCnt,
  output ckPkg::wordT  sum,
  output logic         cout
);

  import ckPkg::*;

  clientT lastGrant;
  wordT   opA;
  wordT   opB;
  logic   opCin;
  logic   carry0;

  // On a tie the client that was not served last wins.
  assign grantAcc = reqAcc & (!reqCnt | (lastGrant == clientCnt));
  assign grantCnt = reqCnt & (!reqAcc | (lastGrant == clientAcc));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lastGrant <= clientCnt;  // Accumulator wins the first tie.
    end else if (grantAcc) begin
      lastGrant <= clientAcc;
    end else if (grantCnt) begin
      lastGrant <= clientCnt;
    end
  end

  assign opA   = grantCnt ? wordT'(cntA) : accA;
  assign opB   = grantCnt ? wordT'(cntB) : accB;
  assign opCin = grantCnt ? 1'b0 : accCin;  // Counter never adds a carry.

  // Bit 0 full add.
  assign sum[0] = opA[0] ^ opB[0] ^ opCin;
  assign carry0 = (opA[0] & opB[0]) | (opCin & (opA[0] ^ opB[0]));

  claAdd15 uAdd (
    .a   (opA[15:1]),
    .b   (opB[15:1]),
    .cin (carry0),
    .sum (sum[15:1])
  );

  // Carry out of bit 15 from its operands and its sum bit.
  assign cout = (opA[15] & opB[15]) |
                ((opA[15] | opB[15]) & !sum[15]);

endmodule

// ==== verilog/checksumAcc.sv ====
`timescale 1ns/1ps

module checksumAcc (
  input  logic        clk,
  input  logic        rstN,
  input  logic        start,
  input  logic        wordValid,
  input  ckPkg::wordT wordData,
  input  logic        grant,
  input  ckPkg::wordT sum,
  input  logic        cout,
  output logic        req,
  output ckPkg::wordT opA,
  output ckPkg::wordT opB,
  output logic        opCin,
  output logic        pending,
  output ckPkg::wordT acc
);

  import ckPkg::*;

  accStateT state;
  wordT     word;
  logic     carry;
  logic     accept;

  assign accept = (state == accIdle) && !start && wordValid;  // Start wins.

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= accIdle;
      acc   <= '0;
      carry <= 1'b0;
    end else begin
      case (state)
        accIdle: begin
          if (start) begin
            acc <= '0;
          end else if (accept) begin
            state <= accAdd;
          end
        end
        accAdd: begin
          if (grant) begin
            acc   <= sum;
            carry <= cout;  // Kept for the fold pass.
            state <= accFold;
          end
        end
        accFold: begin
          if (grant) begin
            acc   <= sum;
            state <= accIdle;
          end
        end
        default: state <= accIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      word <= wordData;
    end
  end

  assign pending = (state != accIdle);
  assign req     = pending;  // Both busy states need the adder.
  assign opA     = acc;
  assign opB     = (state == accFold) ? '0 : word;
  assign opCin   = (state == accFold) ? carry : 1'b0;  // End-around carry.

endmodule

// ==== verilog/wordCounter.sv ====
`timescale 1ns/1ps

module wordCounter #(
  parameter int CountWidth = 16
) (
  input  logic         clk,
  input  logic         rstN,
  input  logic         start,
  input  logic         wordValid,
  input  logic         grant,
  input  ckPkg::countT sum,
  output logic         req,
  output ckPkg::countT opA,
  output ckPkg::countT opB,
  output ckPkg::countT count
);

  import ckPkg::*;

  // Keeps the count modulo 2**CountWidth.
  localparam countT CountMask = countT'((32'd1 << CountWidth) - 32'd1);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      req   <= 1'b0;
      count <= '0;
    end else if (req) begin
      if (grant) begin
        req   <= 1'b0;
        count <= sum & CountMask;
      end
    end else if (start) begin
      count <= '0;
    end else if (wordValid) begin
      req <= 1'b1;  // One pass per word.
    end
  end

  assign opA = count;
  assign opB = countT'(WordStride);

endmodule

// ==== verilog/checksumEngine.sv ====
`timescale 1ns/1ps

module checksumEngine #(
  parameter int CountWidth = 16
) (
  input  logic         clk,
  input  logic         rstN,
  input  logic         start,
  input  logic         wordValid,
  input  ckPkg::wordT  wordData,
  output logic         busy,
  output ckPkg::wordT  checksum,
  output ckPkg::countT byteCount
);

  import ckPkg::*;

  logic  accReq;
  logic  accGrant;
  logic  accCin;
  logic  accPending;
  wordT  accOpA;
  wordT  accOpB;
  wordT  acc;
  logic  cntReq;
  logic  cntGrant;
  countT cntOpA;
  countT cntOpB;
  wordT  addSum;
  logic  addCout;

  checksumAcc uAcc (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .wordValid (wordValid),
    .wordData  (wordData),
    .grant     (accGrant),
    .sum       (addSum),
    .cout      (addCout),
    .req       (accReq),
    .opA       (accOpA),
    .opB       (accOpB),
    .opCin     (accCin),
    .pending   (accPending),
    .acc       (acc)
  );

  wordCounter #(
    .CountWidth (CountWidth)
  ) uCnt (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .wordValid (wordValid),
    .grant     (cntGrant),
    .sum       (countT'(addSum)),
    .req       (cntReq),
    .opA       (cntOpA),
    .opB       (cntOpB),
    .count     (byteCount)
  );

  adderShare uShare (
    .clk      (clk),
    .rstN     (rstN),
    .reqAcc   (accReq),
    .reqCnt   (cntReq),
    .accA     (accOpA),
    .accB     (accOpB),
    .accCin   (accCin),
    .cntA     (cntOpA),
    .cntB     (cntOpB),
    .grantAcc (accGrant),
    .grantCnt (cntGrant),
    .sum      (addSum),
    .cout     (addCout)
  );

  assign busy     = accPending | cntReq;  // Either client still owes a pass.
  assign checksum = ~acc;

endmodule

// ==== test/checksumEngine_chk.sv ====
`timescale 1ns/1ps

module checksumEngine_chk (
  input logic clk,
  input logic rstN,
  input logic wordValid,
  input logic busy,
  input logic accReq,
  input logic accGrant,
  input logic cntReq,
  input logic cntGrant
);

  int failCount = 0;  // Read by the testbench at the end.

  assert property (@(posedge clk) disable iff (!rstN) !(accGrant && cntGrant))
    else begin
      $error("Both adder grants are high.");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN)
                   (accGrant -> accReq) && (cntGrant -> cntReq))
    else begin
      $error("A grant was given without a request.");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) !(wordValid && busy))
    else begin
      $error("A word was strobed while busy and is lost.");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) $rose(busy) |-> ##[1:8] !busy)
    else begin
      $error("Busy stayed high for more than 8 cycles.");
      failCount++;
    end

endmodule

bind checksumEngine checksumEngine_chk uChk (
  .clk       (clk),
  .rstN      (rstN),
  .wordValid (wordValid),
  .busy      (busy),
  .accReq    (accReq),
  .accGrant  (accGrant),
  .cntReq    (cntReq),
  .cntGrant  (cntGrant)
);

// ==== test/checksumEngine_tb.sv ====
`timescale 1ns/1ps

module checksumEngine_tb;

  import ckPkg::*;

  localparam int CountWidth   = 16;
  localparam int WordsPlanned = 88;
  localparam int CycleLimit   = 4 * WordsPlanned + 200;

  logic  clk = 1'b0;
  logic  rstN;
  logic  start;
  logic  wordValid;
  wordT  wordData;
  logic  busy;
  wordT  checksum;
  countT byteCount;
  wordT  modelSum;
  countT modelCount;
  int    cycles = 0;

  checksumEngine #(
    .CountWidth (CountWidth)
  ) u_dut (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .wordValid (wordValid),
    .wordData  (wordData),
    .busy      (busy),
    .checksum  (checksum),
    .byteCount (byteCount)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles, the engine never went idle", cycles);
      $display("Something failed");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

  always @(negedge clk) begin
    if (u_dut.uChk.failCount != 0) begin
      $display("%0d assertion failures in the checker", u_dut.uChk.failCount);
      $display("Something failed");
      $fatal(1, "Checker reported errors.");
    end
  end

  // Ones' complement add, the carry out wraps into bit 0.
  function automatic wordT onesAdd(wordT a, wordT b);
    logic [16:0] full;
    full = {1'b0, a} + {1'b0, b};
    return full[15:0] + wordT'(full[16]);
  endfunction

  task automatic checkWord(string name, wordT got, wordT exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("Something failed");
      $fatal(1, "Word compare failed.");
    end
  endtask

  task automatic checkCount(string name, countT got, countT exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("Something failed");
      $fatal(1, "Count compare failed.");
    end
  endtask

  task automatic checkLevel(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("Something failed");
      $fatal(1, "Level compare failed.");
    end
  endtask

  task automatic waitIdle();
    @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  task automatic sendWord(wordT w);
    while (busy) @(negedge clk);  // Callers arrive on a falling edge.
    @(posedge clk);
    wordValid <= 1'b1;
    wordData  <= w;
    @(posedge clk);
    wordValid <= 1'b0;
  endtask

  // Send one word, step the model, check both outputs once idle.
  task automatic pushWord(wordT w);
    sendWord(w);
    modelSum   = onesAdd(modelSum, w);
    modelCount = countT'((int'(modelCount) + WordStride) % (1 << CountWidth));
    waitIdle();
    checkWord("checksum", checksum, ~modelSum);
    checkCount("byteCount", byteCount, modelCount);
  endtask

  task automatic clearAll();
    waitIdle();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    modelSum   = '0;
    modelCount = '0;
    @(negedge clk);
    checkWord("checksum", checksum, 16'hFFFF);
    checkCount("byteCount", byteCount, '0);
  endtask

  task automatic testReset();
    @(negedge clk);
    checkLevel("busy", busy, 1'b0);
    checkWord("checksum", checksum, 16'hFFFF);
    checkCount("byteCount", byteCount, '0);
  endtask

  task automatic testSingle();
    pushWord(16'h1234);
    checkWord("checksum", checksum, 16'hEDCB);
    checkCount("byteCount", byteCount, 16'd2);
  endtask

  task automatic testRandom();
    clearAll();
    repeat (64) pushWord(wordT'($urandom()));
  endtask

  task automatic testCarry();
    clearAll();
    pushWord(16'hFFFF);
    pushWord(16'hFFFF);
    pushWord(16'h8000);
    pushWord(16'h8001);
    clearAll();
    pushWord(16'h8000);
    pushWord(16'h8000);
    checkWord("checksum", checksum, 16'hFFFE);  // 10000 folds to 0001.
    clearAll();
    pushWord(16'hFFFF);
    pushWord(16'h0001);
    checkWord("checksum", checksum, 16'hFFFE);
  endtask

  task automatic testRestart();
    repeat (5) pushWord(wordT'($urandom()));
    clearAll();
    pushWord(16'h4500);
    pushWord(16'h0030);
    pushWord(16'h4422);
    pushWord(16'h4000);
  endtask

  task automatic testCarryChains();
    clearAll();
    pushWord(16'hAAAA);
    pushWord(16'h5555);
    checkWord("checksum", checksum, 16'h0000);
    clearAll();
    pushWord(16'h7FFF);
    pushWord(16'h0001);
    checkWord("checksum", checksum, 16'h7FFF);
    clearAll();
    pushWord(16'h00FF);
    pushWord(16'hFF01);
    checkWord("checksum", checksum, 16'hFFFE);
  endtask

  initial begin
    void'($urandom(32'h05d3_1e9b));
    rstN       = 1'b0;
    start      = 1'b0;
    wordValid  = 1'b0;
    wordData   = '0;
    modelSum   = '0;
    modelCount = '0;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    testReset();
    testSingle();
    testRandom();
    testCarry();
    testRestart();
    testCarryChains();
    waitIdle();
    if (u_dut.uChk.failCount != 0) begin
      $display("%0d assertion failures in the checker", u_dut.uChk.failCount);
      $display("Something failed");
      $fatal(1, "Checker reported errors.");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== checksumEngine.f ====
verilog/ckPkg.sv
verilog/claAdd15.sv
verilog/adderShare.sv
verilog/checksumAcc.sv
verilog/wordCounter.sv
verilog/checksumEngine.sv
test/checksumEngine_chk.sv
test/checksumEngine_tb.sv

// ==== Bender.yml ====
package:
  name: checksumEngine

sources:
  - verilog/ckPkg.sv
  - verilog/claAdd15.sv
  - verilog/adderShare.sv
  - verilog/checksumAcc.sv
  - verilog/wordCounter.sv
  - verilog/checksumEngine.sv
  - target: test
    files:
      - test/checksumEngine_chk.sv
      - test/checksumEngine_tb.sv
